//--- hw/soc_bus_pkg.sv
package soc_bus_pkg;

    // bus geometry
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // top word-address bits pick an 8 MB region
    localparam int REGION_W = 9;

    localparam logic [REGION_W-1:0] REGION_RAM = 9'd0;
    localparam logic [REGION_W-1:0] REGION_SYS = 9'd1;

    // value returned by the id register
    localparam logic [DATA_W-1:0] SYS_ID = 32'h20191028;

    // system register offsets, low four word-address bits
    localparam logic [3:0] REG_ID      = 4'h0;
    localparam logic [3:0] REG_SCRATCH = 4'h1;
    localparam logic [3:0] REG_BUSERR  = 4'h2;
    localparam logic [3:0] REG_UPTIME  = 4'h3;
    localparam logic [3:0] REG_IRQ     = 4'h4;

endpackage : soc_bus_pkg

//--- hw/wb_if.sv
`timescale 1ns/1ps

interface wb_if;

    // request side
    logic                             cyc;
    logic                             stb;
    logic                             we;
    logic [soc_bus_pkg::ADDR_W-1:0]   addr;
    logic [soc_bus_pkg::DATA_W-1:0]   wdata;
    logic [soc_bus_pkg::SEL_W-1:0]    sel;

    // response side
    logic                             ack;
    logic                             stall;
    logic                             err;
    logic [soc_bus_pkg::DATA_W-1:0]   rdata;

    modport master (
        output cyc, stb, we, addr, wdata, sel,
        input  ack, stall, err, rdata
    );

    modport slave (
        input  cyc, stb, we, addr, wdata, sel,
        output ack, stall, err, rdata
    );

endinterface : wb_if

//--- hw/wb_pri_arbiter.sv
`timescale 1ns/1ps

module wb_pri_arbiter (
    input  logic i_clk,
    input  logic i_rst_n,
    wb_if.slave  i_a,
    wb_if.slave  i_b,
    wb_if.master o_m
);

    // 0 = master a owns the bus, 1 = master b
    logic owner_b;
    logic owner_cyc;

    assign owner_cyc = owner_b ? i_b.cyc : i_a.cyc;

    // grant only moves once the current owner has dropped cyc
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            owner_b <= 1'b0;
        end else if (!owner_cyc) begin
            // a wins ties, rest on a when idle
            owner_b <= !i_a.cyc && i_b.cyc;
        end
    end

    // owner's request onto the shared bus
    assign o_m.cyc   = owner_cyc;
    assign o_m.stb   = owner_b ? i_b.stb   : i_a.stb;
    assign o_m.we    = owner_b ? i_b.we    : i_a.we;
    assign o_m.addr  = owner_b ? i_b.addr  : i_a.addr;
    assign o_m.wdata = owner_b ? i_b.wdata : i_a.wdata;
    assign o_m.sel   = owner_b ? i_b.sel   : i_a.sel;

    // responses reach the owner only, the other side waits on stall
    assign i_a.ack   = !owner_b && o_m.ack;
    assign i_a.err   = !owner_b && o_m.err;
    assign i_a.stall = owner_b || o_m.stall;

    assign i_b.ack   = owner_b && o_m.ack;
    assign i_b.err   = owner_b && o_m.err;
    assign i_b.stall = !owner_b || o_m.stall;

    // read data is broadcast, only the acked master looks at it
    assign i_a.rdata = o_m.rdata;
    assign i_b.rdata = o_m.rdata;

endmodule : wb_pri_arbiter

//--- hw/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    wb_if.slave                            i_m,
    wb_if.master                           o_ram,
    wb_if.master                           o_sys,
    output logic                           o_err_pulse,
    output logic [soc_bus_pkg::ADDR_W-1:0] o_err_addr
);

    logic [soc_bus_pkg::REGION_W-1:0] region;
    logic                             ram_hit;
    logic                             sys_hit;
    logic                             unmapped;
    logic                             err_q;
    logic                             ack_q;
    logic [soc_bus_pkg::DATA_W-1:0]   rdata_q;

    assign region   = i_m.addr[soc_bus_pkg::ADDR_W-1 -: soc_bus_pkg::REGION_W];
    assign ram_hit  = (region == soc_bus_pkg::REGION_RAM);
    assign sys_hit  = (region == soc_bus_pkg::REGION_SYS);
    // former peripheral windows land here too
    assign unmapped = i_m.cyc && i_m.stb && !ram_hit && !sys_hit;

    // shared request lines, strobe qualified per slave
    assign o_ram.cyc   = i_m.cyc;
    assign o_ram.stb   = i_m.stb && ram_hit;
    assign o_ram.we    = i_m.we;
    assign o_ram.addr  = i_m.addr;
    assign o_ram.wdata = i_m.wdata;
    assign o_ram.sel   = i_m.sel;

    assign o_sys.cyc   = i_m.cyc;
    assign o_sys.stb   = i_m.stb && sys_hit;
    assign o_sys.we    = i_m.we;
    assign o_sys.addr  = i_m.addr;
    assign o_sys.wdata = i_m.wdata;
    assign o_sys.sel   = i_m.sel;

    assign i_m.stall = (ram_hit && o_ram.stall) || (sys_hit && o_sys.stall);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= o_ram.ack || o_sys.ack;
            err_q <= unmapped;
        end
    end

    // return data and failing address
    always_ff @(posedge i_clk) begin
        if (o_ram.ack) begin
            rdata_q <= o_ram.rdata;
        end else if (o_sys.ack) begin
            rdata_q <= o_sys.rdata;
        end else begin
            rdata_q <= '0;
        end
        if (unmapped) begin
            o_err_addr <= i_m.addr;
        end
    end

    assign i_m.ack     = ack_q;
    assign i_m.err     = err_q;
    assign i_m.rdata   = rdata_q;
    assign o_err_pulse = err_q;

endmodule : bus_decoder

//--- hw/sys_info_regs.sv
`timescale 1ns/1ps

module sys_info_regs (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    wb_if.slave                            i_bus,
    input  logic                           i_err_pulse,
    input  logic [soc_bus_pkg::ADDR_W-1:0] i_err_addr,
    output logic                           o_irq
);

    logic                           req;
    logic [soc_bus_pkg::DATA_W-1:0] scratch;
    logic [soc_bus_pkg::DATA_W-1:0] uptime;
    logic [soc_bus_pkg::ADDR_W-1:0] err_addr;
    logic                           irq_flag;
    logic                           ack_q;
    logic [soc_bus_pkg::DATA_W-1:0] rdata_q;

    assign req = i_bus.cyc && i_bus.stb;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q    <= 1'b0;
            scratch  <= '0;
            irq_flag <= 1'b0;
            uptime   <= '0;
            err_addr <= '0;
        end else begin
            ack_q <= req;
            // byte selects are ignored for register writes
            if (req && i_bus.we) begin
                case (i_bus.addr[3:0])
                    soc_bus_pkg::REG_SCRATCH: scratch  <= i_bus.wdata;
                    soc_bus_pkg::REG_IRQ:     irq_flag <= i_bus.wdata[0];
                    default: ;
                endcase
            end
            // top bit is sticky once the low bits roll over into it
            uptime <= {uptime[soc_bus_pkg::DATA_W-1] | (&uptime[soc_bus_pkg::DATA_W-2:0]),
                       uptime[soc_bus_pkg::DATA_W-2:0] + 1'b1};
            if (i_err_pulse) begin
                err_addr <= i_err_addr;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req) begin
            case (i_bus.addr[3:0])
                soc_bus_pkg::REG_ID:      rdata_q <= soc_bus_pkg::SYS_ID;
                soc_bus_pkg::REG_SCRATCH: rdata_q <= scratch;
                // reported as a byte address
                soc_bus_pkg::REG_BUSERR:  rdata_q <= {err_addr, 2'b00};
                soc_bus_pkg::REG_UPTIME:  rdata_q <= uptime;
                soc_bus_pkg::REG_IRQ:     rdata_q <= {{(soc_bus_pkg::DATA_W-1){1'b0}}, irq_flag};
                default:                  rdata_q <= '0;
            endcase
        end
    end

    assign i_bus.ack   = ack_q;
    assign i_bus.stall = 1'b0;
    assign i_bus.err   = 1'b0;
    assign i_bus.rdata = rdata_q;
    assign o_irq       = irq_flag;

endmodule : sys_info_regs

//--- hw/bus_ram.sv
`timescale 1ns/1ps

module bus_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic i_clk,
    input  logic i_rst_n,
    wb_if.slave  i_bus
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [soc_bus_pkg::DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]               idx;
    logic                           req;
    logic                           ack_q;
    logic [soc_bus_pkg::DATA_W-1:0] rdata_q;

    // upper address bits are dropped, so the array repeats through the region
    assign idx = i_bus.addr[IDX_W-1:0];
    assign req = i_bus.cyc && i_bus.stb;

    always_ff @(posedge i_clk) begin
        if (req) begin
            if (i_bus.we) begin
                for (int i = 0; i < soc_bus_pkg::SEL_W; i++) begin
                    if (i_bus.sel[i]) begin
                        mem[idx][8*i +: 8] <= i_bus.wdata[8*i +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    assign i_bus.ack   = ack_q;
    assign i_bus.stall = 1'b0;
    assign i_bus.err   = 1'b0;
    assign i_bus.rdata = rdata_q;

endmodule : bus_ram

//--- hw/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,

    // cpu data port
    input  logic                           i_d_cyc,
    input  logic                           i_d_stb,
    input  logic                           i_d_we,
    input  logic [soc_bus_pkg::ADDR_W-1:0] i_d_addr,
    input  logic [soc_bus_pkg::DATA_W-1:0] i_d_wdata,
    input  logic [soc_bus_pkg::SEL_W-1:0]  i_d_sel,
    output logic                           o_d_ack,
    output logic                           o_d_stall,
    output logic                           o_d_err,

    // cpu fetch port
    input  logic                           i_f_cyc,
    input  logic                           i_f_stb,
    input  logic                           i_f_we,
    input  logic [soc_bus_pkg::ADDR_W-1:0] i_f_addr,
    input  logic [soc_bus_pkg::DATA_W-1:0] i_f_wdata,
    input  logic [soc_bus_pkg::SEL_W-1:0]  i_f_sel,
    output logic                           o_f_ack,
    output logic                           o_f_stall,
    output logic                           o_f_err,

    // debug port
    input  logic                           i_g_cyc,
    input  logic                           i_g_stb,
    input  logic                           i_g_we,
    input  logic [soc_bus_pkg::ADDR_W-1:0] i_g_addr,
    input  logic [soc_bus_pkg::DATA_W-1:0] i_g_wdata,
    input  logic [soc_bus_pkg::SEL_W-1:0]  i_g_sel,
    output logic                           o_g_ack,
    output logic                           o_g_stall,
    output logic                           o_g_err,

    output logic [soc_bus_pkg::DATA_W-1:0] o_rdata,
    output logic                           o_irq
);

    wb_if d_bus ();
    wb_if f_bus ();
    wb_if g_bus ();
    wb_if cpu_bus ();
    wb_if main_bus ();
    wb_if ram_bus ();
    wb_if sys_bus ();

    logic                           err_pulse;
    logic [soc_bus_pkg::ADDR_W-1:0] err_addr;

    assign d_bus.cyc   = i_d_cyc;
    assign d_bus.stb   = i_d_stb;
    assign d_bus.we    = i_d_we;
    assign d_bus.addr  = i_d_addr;
    assign d_bus.wdata = i_d_wdata;
    assign d_bus.sel   = i_d_sel;
    assign o_d_ack     = d_bus.ack;
    assign o_d_stall   = d_bus.stall;
    assign o_d_err     = d_bus.err;

    assign f_bus.cyc   = i_f_cyc;
    assign f_bus.stb   = i_f_stb;
    assign f_bus.we    = i_f_we;
    assign f_bus.addr  = i_f_addr;
    assign f_bus.wdata = i_f_wdata;
    assign f_bus.sel   = i_f_sel;
    assign o_f_ack     = f_bus.ack;
    assign o_f_stall   = f_bus.stall;
    assign o_f_err     = f_bus.err;

    assign g_bus.cyc   = i_g_cyc;
    assign g_bus.stb   = i_g_stb;
    assign g_bus.we    = i_g_we;
    assign g_bus.addr  = i_g_addr;
    assign g_bus.wdata = i_g_wdata;
    assign g_bus.sel   = i_g_sel;
    assign o_g_ack     = g_bus.ack;
    assign o_g_stall   = g_bus.stall;
    assign o_g_err     = g_bus.err;

    // read data goes to all three masters unchanged
    assign o_rdata = main_bus.rdata;

    // data beats fetch
    wb_pri_arbiter u_cpu_arb (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_a     (d_bus),
        .i_b     (f_bus),
        .o_m     (cpu_bus)
    );

    // cpu beats debug
    wb_pri_arbiter u_main_arb (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_a     (cpu_bus),
        .i_b     (g_bus),
        .o_m     (main_bus)
    );

    bus_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_m         (main_bus),
        .o_ram       (ram_bus),
        .o_sys       (sys_bus),
        .o_err_pulse (err_pulse),
        .o_err_addr  (err_addr)
    );

    bus_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_bus   (ram_bus)
    );

    sys_info_regs u_sys (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_bus       (sys_bus),
        .i_err_pulse (err_pulse),
        .i_err_addr  (err_addr),
        .o_irq       (o_irq)
    );

endmodule : soc_bus_top

//--- sim/soc_bus_chk.sv
`timescale 1ns/1ps

module soc_bus_chk (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_d_cyc,
    input logic i_d_ack,
    input logic i_d_err,
    input logic i_f_cyc,
    input logic i_f_ack,
    input logic i_f_err,
    input logic i_g_cyc,
    input logic i_g_ack,
    input logic i_g_err
);

    int         fail_count = 0;
    logic [2:0] resp;

    assign resp = {i_d_ack || i_d_err, i_f_ack || i_f_err, i_g_ack || i_g_err};

    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_d_ack && i_d_err) && !(i_f_ack && i_f_err) && !(i_g_ack && i_g_err))
        else begin
            fail_count++;
            $error("ack and err high together on one master");
        end

    // a response only inside the master's own cycle
    a_resp_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!resp[2] || i_d_cyc) && (!resp[1] || i_f_cyc) && (!resp[0] || i_g_cyc))
        else begin
            fail_count++;
            $error("ack or err outside the master's cycle");
        end

    a_one_resp: assert property (@(posedge i_clk) disable iff (!i_rst_n) $onehot0(resp))
        else begin
            fail_count++;
            $error("more than one master answered in one cycle");
        end

endmodule : soc_bus_chk

bind soc_bus_top soc_bus_chk u_chk (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_d_cyc (i_d_cyc),
    .i_d_ack (o_d_ack),
    .i_d_err (o_d_err),
    .i_f_cyc (i_f_cyc),
    .i_f_ack (o_f_ack),
    .i_f_err (o_f_err),
    .i_g_cyc (i_g_cyc),
    .i_g_ack (o_g_ack),
    .i_g_err (o_g_err)
);

//--- sim/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb;

    localparam int          RAM_WORDS = 1024;
    localparam int          TIMEOUT   = 64;
    localparam logic [31:0] ID_WORD   = 32'h20191028;
    // first word of the system register region
    localparam logic [29:0] SYS_BASE  = 30'h0020_0000;

    logic        i_clk;
    logic        i_rst_n;

    // index 0 data, 1 fetch, 2 debug
    logic        cyc   [3];
    logic        stb   [3];
    logic        we    [3];
    logic [29:0] addr  [3];
    logic [31:0] wdata [3];
    logic [3:0]  sel   [3];
    logic        ack   [3];
    logic        stall [3];
    logic        err   [3];
    logic [31:0] rdata;
    logic        irq;

    // reference state
    logic [31:0] ref_mem [RAM_WORDS];
    logic [31:0] ref_scratch;
    logic        ref_irq;
    logic [29:0] ref_err_addr;

    logic [31:0] rng;
    int          errors;
    string       name_q [$];
    logic [31:0] exp_q  [$];
    logic [31:0] act_q  [$];

    soc_bus_top #(
        .RAM_WORDS (RAM_WORDS)
    ) u_dut (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_d_cyc   (cyc[0]),
        .i_d_stb   (stb[0]),
        .i_d_we    (we[0]),
        .i_d_addr  (addr[0]),
        .i_d_wdata (wdata[0]),
        .i_d_sel   (sel[0]),
        .o_d_ack   (ack[0]),
        .o_d_stall (stall[0]),
        .o_d_err   (err[0]),
        .i_f_cyc   (cyc[1]),
        .i_f_stb   (stb[1]),
        .i_f_we    (we[1]),
        .i_f_addr  (addr[1]),
        .i_f_wdata (wdata[1]),
        .i_f_sel   (sel[1]),
        .o_f_ack   (ack[1]),
        .o_f_stall (stall[1]),
        .o_f_err   (err[1]),
        .i_g_cyc   (cyc[2]),
        .i_g_stb   (stb[2]),
        .i_g_we    (we[2]),
        .i_g_addr  (addr[2]),
        .i_g_wdata (wdata[2]),
        .i_g_sel   (sel[2]),
        .o_g_ack   (ack[2]),
        .o_g_stall (stall[2]),
        .o_g_err   (err[2]),
        .o_rdata   (rdata),
        .o_irq     (irq)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #10 i_clk = ~i_clk;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // random alias of a ram word inside the 8 MB ram region
    function automatic logic [29:0] alias_addr(input logic [29:0] idx);
        logic [31:0] k;
        k = next_rand() % (32'h0020_0000 / RAM_WORDS);
        return 30'(k * RAM_WORDS + idx);
    endfunction

    function automatic logic [31:0] expected_read(input logic [29:0] a);
        if (a[29:21] == 9'd0) begin
            return ref_mem[a % RAM_WORDS];
        end
        if (a[29:21] != 9'd1) begin
            return 32'h0;
        end
        case (a[3:0])
            4'h0:    return ID_WORD;
            4'h1:    return ref_scratch;
            4'h2:    return {ref_err_addr, 2'b00};
            4'h4:    return {31'd0, ref_irq};
            default: return 32'h0;
        endcase
    endfunction

    task automatic model_write(input logic [29:0] a, input logic [31:0] d, input logic [3:0] s);
        if (a[29:21] == 9'd0) begin
            for (int i = 0; i < 4; i++) begin
                if (s[i]) begin
                    ref_mem[a % RAM_WORDS][8*i +: 8] = d[8*i +: 8];
                end
            end
        end else if (a[29:21] == 9'd1) begin
            // registers take the full word whatever sel says
            if (a[3:0] == 4'h1) begin
                ref_scratch = d;
            end
            if (a[3:0] == 4'h4) begin
                ref_irq = d[0];
            end
        end
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        $display("errors: %0d", errors);
        $display("TEST FAIL");
        $finish;
    endtask

    // one single-beat cycle on master m
    task automatic bus_access(
        input  int          m,
        input  logic        wr,
        input  logic [29:0] a,
        input  logic [31:0] d,
        input  logic [3:0]  s,
        output logic [31:0] data,
        output logic        got_ack,
        output logic        got_err,
        output time         t_done
    );
        int waited;
        @(negedge i_clk);
        cyc[m]   = 1'b1;
        stb[m]   = 1'b1;
        we[m]    = wr;
        addr[m]  = a;
        wdata[m] = d;
        sel[m]   = s;
        #1;
        waited = 0;
        // request held as is while stalled
        while (stall[m]) begin
            @(negedge i_clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                abort_on_timeout($sformatf("grant on master %0d", m));
            end
        end
        @(negedge i_clk);
        stb[m] = 1'b0;
        #1;
        waited = 0;
        while (!ack[m] && !err[m]) begin
            @(negedge i_clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                abort_on_timeout($sformatf("ack or err on master %0d", m));
            end
        end
        data    = rdata;
        got_ack = ack[m];
        got_err = err[m];
        t_done  = $time;
        @(negedge i_clk);
        cyc[m] = 1'b0;
        we[m]  = 1'b0;
    endtask

    task automatic write_word(input int m, input logic [29:0] a, input logic [31:0] d,
                              input logic [3:0] s);
        logic [31:0] unused;
        logic        got_ack;
        logic        got_err;
        time         t;
        bus_access(m, 1'b1, a, d, s, unused, got_ack, got_err, t);
        check("write ack", 1, got_ack);
        model_write(a, d, s);
    endtask

    task automatic read_word(input int m, input logic [29:0] a, input string name,
                             output logic [31:0] data, output time t_done);
        logic [31:0] exp;
        logic        got_ack;
        logic        got_err;
        exp = expected_read(a);
        bus_access(m, 1'b0, a, 32'h0, 4'hF, data, got_ack, got_err, t_done);
        check({name, " ack"}, 1, got_ack);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(data);
    endtask

    // compares every completed read with its reference value
    initial begin
        forever begin
            @(posedge i_clk);
            while (act_q.size() > 0) begin
                check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
            end
        end
    end

    initial begin
        logic [29:0] idx [8];
        logic [29:0] a;
        logic [29:0] a_f;
        logic [31:0] rd;
        logic [31:0] up_first;
        logic [31:0] up_second;
        logic        got_ack;
        logic        got_err;
        time         t_d;
        time         t_f;
        time         t_g;
        time         t_cpu_end;
        int          waited;

        errors       = 0;
        rng          = 32'h6dc49b4b;
        ref_scratch  = '0;
        ref_irq      = 1'b0;
        ref_err_addr = '0;
        i_rst_n      = 1'b0;
        for (int m = 0; m < 3; m++) begin
            cyc[m]   = 1'b0;
            stb[m]   = 1'b0;
            we[m]    = 1'b0;
            addr[m]  = '0;
            wdata[m] = '0;
            sel[m]   = '0;
        end
        repeat (16) @(negedge i_clk);
        check("reset outputs", 0, {ack[0], ack[1], ack[2], err[0], err[1], err[2], irq});
        i_rst_n = 1'b1;

        bus_access(0, 1'b0, SYS_BASE + 30'd3, 32'h0, 4'hF, up_first, got_ack, got_err, t_d);
        bus_access(2, 1'b0, SYS_BASE + 30'd3, 32'h0, 4'hF, up_second, got_ack, got_err, t_d);
        check("uptime increasing", 1, up_second > up_first);

        // full words first so partial lanes are never unknown
        for (int i = 0; i < 8; i++) begin
            idx[i] = 30'(next_rand() % RAM_WORDS);
            write_word(i % 3, alias_addr(idx[i]), next_rand(), 4'hF);
        end
        for (int i = 0; i < 16; i++) begin
            a = alias_addr(idx[next_rand() % 8]);
            write_word(i % 3, a, next_rand(), 4'(next_rand()));
        end
        for (int i = 0; i < 8; i++) begin
            read_word(i % 3, alias_addr(idx[i]), "ram read", rd, t_d);
        end

        read_word(1, SYS_BASE, "id register", rd, t_d);
        write_word(0, SYS_BASE + 30'd1, next_rand(), 4'h3);
        read_word(2, SYS_BASE + 30'd1, "scratch", rd, t_d);
        for (int off = 5; off < 16; off++) begin
            read_word(off % 3, SYS_BASE + 30'(off), "unused offset", rd, t_d);
        end

        write_word(0, SYS_BASE + 30'd4, 32'h1, 4'hF);
        check("irq raised", 1, irq);
        read_word(2, SYS_BASE + 30'd4, "irq set read", rd, t_d);
        write_word(1, SYS_BASE + 30'd4, 32'h0, 4'hF);
        check("irq cleared", 0, irq);
        read_word(0, SYS_BASE + 30'd4, "irq clear read", rd, t_d);

        // old peripheral window, now unmapped
        a = {9'h0A5, 21'h012345};
        bus_access(2, 1'b0, a, 32'h0, 4'hF, rd, got_ack, got_err, t_g);
        check("unmapped err", 1, got_err);
        check("unmapped ack", 0, got_ack);
        ref_err_addr = a;
        read_word(0, SYS_BASE + 30'd2, "bus error address", rd, t_d);

        a   = alias_addr(idx[0]);
        a_f = alias_addr(idx[1]);
        fork
            read_word(0, a, "arb data read", rd, t_d);
            read_word(1, a_f, "arb fetch read", rd, t_f);
        join
        check("data before fetch", 1, t_d < t_f);

        fork
            begin
                read_word(0, a, "cpu read", rd, t_d);
                t_cpu_end = $time;
            end
            begin
                @(negedge i_clk);
                read_word(2, a_f, "debug read", rd, t_g);
            end
        join
        // grant only after the cpu drops cyc, then two more edges to the ack
        check("debug after cpu", 1, t_g > t_cpu_end + 40);

        waited = 0;
        while (act_q.size() > 0) begin
            @(negedge i_clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_on_timeout("the read comparisons to finish");
            end
        end
        errors += u_dut.u_chk.fail_count;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : soc_bus_tb

//--- soc_bus_top.f
hw/soc_bus_pkg.sv
hw/wb_if.sv
hw/wb_pri_arbiter.sv
hw/bus_decoder.sv
hw/sys_info_regs.sv
hw/bus_ram.sv
hw/soc_bus_top.sv
sim/soc_bus_chk.sv
sim/soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - hw/soc_bus_pkg.sv
  - hw/wb_if.sv
  - hw/wb_pri_arbiter.sv
  - hw/bus_decoder.sv
  - hw/sys_info_regs.sv
  - hw/bus_ram.sv
  - hw/soc_bus_top.sv
  - target: simulation
    files:
      - sim/soc_bus_chk.sv
      - sim/soc_bus_tb.sv
